//--- core_defs.svh
/*
 * Core-wide constants for the single-cycle RV32I core.
 * Include this where widths, the reset vector, opcodes or
 * ALU and write-back select codes are needed.
 */
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

`define XLEN        32
`define RESET_PC    32'h0000_0000

// Major opcodes, instr[6:0]
`define OP_LOAD     7'b0000011
`define OP_OPIMM    7'b0010011
`define OP_AUIPC    7'b0010111
`define OP_STORE    7'b0100011
`define OP_OP       7'b0110011
`define OP_LUI      7'b0110111
`define OP_BRANCH   7'b1100011
`define OP_JALR     7'b1100111
`define OP_JAL      7'b1101111

// ALU operations
`define ALU_ADD     4'd0
`define ALU_SUB     4'd1
`define ALU_SLL     4'd2
`define ALU_SLT     4'd3
`define ALU_SLTU    4'd4
`define ALU_XOR     4'd5
`define ALU_SRL     4'd6
`define ALU_SRA     4'd7
`define ALU_OR      4'd8
`define ALU_AND     4'd9
`define ALU_PASSB   4'd10   // LUI

// Write-back sources
`define WB_ALU      2'd0
`define WB_MEM      2'd1
`define WB_PC4      2'd2

// Access sizes, match funct3[1:0] of loads and stores
`define MEM_BYTE    2'd0
`define MEM_HALF    2'd1
`define MEM_WORD    2'd2

`endif

//--- isaPkg.sv
/*
 * Instruction-field and data-word types of the RV32I ISA.
 * Shared by the decoder, the datapath blocks and the top level.
 */
`include "core_defs.svh"

package isaPkg;

    // Data or address word
    typedef logic [`XLEN-1:0] wordT;

    // Instruction fields
    typedef logic [6:0] opcodeT;
    typedef logic [2:0] funct3T;
    typedef logic [6:0] funct7T;
    typedef logic [4:0] regIdxT;

endpackage

//--- ctrlPkg.sv
/*
 * Control-word types produced by the decoder.
 * The ctrlT struct carries every per-instruction control bit
 * from the controller into the datapath.
 */
package ctrlPkg;

    typedef logic [3:0] aluCtrlT;   // ALU_* codes
    typedef logic [1:0] wbSelT;     // WB_* codes
    typedef logic [1:0] memLenT;    // Byte 0, half 1, word 2

    typedef struct packed {
        logic    regWrite;
        logic    memRead;
        logic    memWrite;
        logic    branch;     // Conditional branch
        logic    jump;       // JAL
        logic    jumpReg;    // JALR
        logic    aluSrcA;    // 1 selects PC
        logic    aluSrcB;    // 1 selects immediate
        aluCtrlT aluCtrl;
        wbSelT   wbSel;
        memLenT  memLen;
        logic    memSigned;
    } ctrlT;

endpackage

//--- controller.sv
/*
 * Instruction decoder. Turns opcode, funct3 and funct7 into the
 * control struct that steers the datapath for one instruction.
 * Purely combinational; unknown opcodes give an inactive word.
 */
`timescale 1ns/1ps
`include "core_defs.svh"

module controller import isaPkg::*, ctrlPkg::*; (
    input  opcodeT opcode,
    input  funct3T funct3,
    input  funct7T funct7,
    output ctrlT   ctrl
);

    // ALU op for the register and immediate groups
    // alt picks SUB over ADD and SRA over SRL
    function automatic aluCtrlT aluFromFunct3(input funct3T f3, input logic alt);
        aluCtrlT op;
        case (f3)
            3'b000:  op = alt ? `ALU_SUB : `ALU_ADD;
            3'b001:  op = `ALU_SLL;
            3'b010:  op = `ALU_SLT;
            3'b011:  op = `ALU_SLTU;
            3'b100:  op = `ALU_XOR;
            3'b101:  op = alt ? `ALU_SRA : `ALU_SRL;
            3'b110:  op = `ALU_OR;
            default: op = `ALU_AND;
        endcase
        return op;
    endfunction

    always_comb begin
        ctrl = '0;
        case (opcode)
            `OP_LUI: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrcB  = 1'b1;
                ctrl.aluCtrl  = `ALU_PASSB;
                ctrl.wbSel    = `WB_ALU;
            end
            `OP_AUIPC: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrcA  = 1'b1;   // PC + imm
                ctrl.aluSrcB  = 1'b1;
                ctrl.aluCtrl  = `ALU_ADD;
                ctrl.wbSel    = `WB_ALU;
            end
            `OP_JAL: begin
                ctrl.regWrite = 1'b1;
                ctrl.jump     = 1'b1;
                ctrl.aluSrcA  = 1'b1;   // Target = PC + imm
                ctrl.aluSrcB  = 1'b1;
                ctrl.aluCtrl  = `ALU_ADD;
                ctrl.wbSel    = `WB_PC4;
            end
            `OP_JALR: begin
                ctrl.regWrite = 1'b1;
                ctrl.jumpReg  = 1'b1;
                ctrl.aluSrcB  = 1'b1;   // Target = rs1 + imm
                ctrl.aluCtrl  = `ALU_ADD;
                ctrl.wbSel    = `WB_PC4;
            end
            `OP_BRANCH: begin
                ctrl.branch   = 1'b1;
                ctrl.aluSrcA  = 1'b1;
                ctrl.aluSrcB  = 1'b1;
                ctrl.aluCtrl  = `ALU_ADD;
            end
            `OP_LOAD: begin
                ctrl.regWrite  = 1'b1;
                ctrl.memRead   = 1'b1;
                ctrl.aluSrcB   = 1'b1;
                ctrl.aluCtrl   = `ALU_ADD;
                ctrl.wbSel     = `WB_MEM;
                ctrl.memLen    = funct3[1:0];
                ctrl.memSigned = ~funct3[2];   // LBU and LHU have bit 2 set
            end
            `OP_STORE: begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrcB  = 1'b1;
                ctrl.aluCtrl  = `ALU_ADD;
                ctrl.memLen   = funct3[1:0];
            end
            `OP_OPIMM: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrcB  = 1'b1;
                // funct7 only matters for the right shift
                ctrl.aluCtrl  = aluFromFunct3(funct3, (funct3 == 3'b101) && funct7[5]);
                ctrl.wbSel    = `WB_ALU;
            end
            `OP_OP: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluCtrl  = aluFromFunct3(funct3, funct7[5]);
                ctrl.wbSel    = `WB_ALU;
            end
            default: ctrl = '0;   // No-op
        endcase
    end

endmodule

//--- alu.sv
/*
 * RV32I ALU. Arithmetic, logic, shifts, compares and a
 * pass-through of operand b for LUI. Purely combinational.
 */
`timescale 1ns/1ps
`include "core_defs.svh"

module alu import isaPkg::*, ctrlPkg::*; (
    input  wordT    a,
    input  wordT    b,
    input  aluCtrlT op,
    output wordT    result
);

    logic [4:0] shamt;

    assign shamt = b[4:0];   // Only the low five bits shift

    always_comb begin
        case (op)
            `ALU_ADD:   result = a + b;
            `ALU_SUB:   result = a - b;
            `ALU_SLL:   result = a << shamt;
            `ALU_SLT:   result = wordT'($signed(a) < $signed(b));
            `ALU_SLTU:  result = wordT'(a < b);
            `ALU_XOR:   result = a ^ b;
            `ALU_SRL:   result = a >> shamt;
            `ALU_SRA:   result = wordT'($signed(a) >>> shamt);
            `ALU_OR:    result = a | b;
            `ALU_AND:   result = a & b;
            `ALU_PASSB: result = b;
            default:    result = '0;
        endcase
    end

endmodule

//--- regFile.sv
/*
 * 32-entry integer register file. Two combinational read ports
 * and one write port on the rising edge. x0 always reads zero.
 */
`timescale 1ns/1ps

module regFile import isaPkg::*; (
    input  logic   clk,
    input  logic   rstN,
    input  regIdxT rs1,
    input  regIdxT rs2,
    input  regIdxT rd,
    input  logic   we,
    input  wordT   wdata,
    output wordT   rdata1,
    output wordT   rdata2
);

    wordT regs [1:31];   // x0 is not stored

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd != '0)) begin
            regs[rd] <= wdata;
        end
    end

    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- immGen.sv
/*
 * Immediate generator. Picks the format from the opcode and
 * builds the sign-extended I, S, B, U or J immediate.
 */
`timescale 1ns/1ps
`include "core_defs.svh"

module immGen import isaPkg::*; (
    input  wordT instr,
    output wordT imm
);

    opcodeT opcode;

    assign opcode = instr[6:0];

    always_comb begin
        case (opcode)
            `OP_OPIMM, `OP_LOAD, `OP_JALR:
                imm = {{20{instr[31]}}, instr[31:20]};
            `OP_STORE:
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            `OP_BRANCH:   // Bit 0 always zero
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                       instr[11:8], 1'b0};
            `OP_LUI, `OP_AUIPC:
                imm = {instr[31:12], 12'b0};
            `OP_JAL:
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            default:
                imm = '0;
        endcase
    end

endmodule

//--- loadStoreUnit.sv
/*
 * Byte-lane handling between the core and data memory.
 * Stores: replicate the data over the lanes and raise the mask
 * only on the addressed bytes. Loads: shift the addressed byte or
 * halfword down and sign or zero extend it.
 */
`timescale 1ns/1ps
`include "core_defs.svh"

module loadStoreUnit import isaPkg::*, ctrlPkg::*; (
    input  logic [1:0] addrLow,
    input  wordT       storeData,
    input  memLenT     memLen,
    input  logic       memSigned,
    output wordT       wdata,
    output logic [3:0] wmask,
    input  wordT       rdata,
    output wordT       loadData
);

    wordT shifted;

    // Store side
    always_comb begin
        case (memLen)
            `MEM_BYTE: begin
                wdata = {4{storeData[7:0]}};
                wmask = 4'b0001 << addrLow;
            end
            `MEM_HALF: begin
                wdata = {2{storeData[15:0]}};
                wmask = addrLow[1] ? 4'b1100 : 4'b0011;
            end
            default: begin   // Word
                wdata = storeData;
                wmask = 4'b1111;
            end
        endcase
    end

    assign shifted = rdata >> {addrLow, 3'b000};   // Lane to bit 0

    // Load side
    always_comb begin
        case (memLen)
            `MEM_BYTE:
                loadData = {{24{memSigned & shifted[7]}}, shifted[7:0]};
            `MEM_HALF:
                loadData = {{16{memSigned & shifted[15]}}, shifted[15:0]};
            default:
                loadData = rdata;
        endcase
    end

endmodule

//--- cpuCore.sv
/*
 * Single-cycle RV32I core, one instruction retired per clock.
 * Instruction and data memories are outside with combinational
 * reads; data writes land on the rising edge while dmemWe is high.
 */
`timescale 1ns/1ps
`include "core_defs.svh"

module cpuCore import isaPkg::*, ctrlPkg::*; (
    input  logic       clk,
    input  logic       rstN,
    output wordT       pc,
    input  wordT       instr,
    output wordT       dmemAddr,
    output wordT       dmemWdata,
    output logic [3:0] dmemWmask,
    output logic       dmemWe,
    input  wordT       dmemRdata
);

    ctrlT   ctrl;
    opcodeT opcode;
    funct3T funct3;
    funct7T funct7;
    regIdxT rs1, rs2, rd;
    wordT   imm, rdata1, rdata2;
    wordT   aluA, aluB, aluResult;
    wordT   loadData, wbData;
    wordT   pcPlus4, nextPc;
    logic   taken;

    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign funct7 = instr[31:25];

    controller u_ctrl (.opcode(opcode), .funct3(funct3), .funct7(funct7), .ctrl(ctrl));

    immGen u_imm (.instr(instr), .imm(imm));

    regFile u_rf (
        .clk(clk), .rstN(rstN),
        .rs1(rs1), .rs2(rs2), .rd(rd),
        .we(ctrl.regWrite), .wdata(wbData),
        .rdata1(rdata1), .rdata2(rdata2)
    );

    assign aluA = ctrl.aluSrcA ? pc : rdata1;
    assign aluB = ctrl.aluSrcB ? imm : rdata2;

    alu u_alu (.a(aluA), .b(aluB), .op(ctrl.aluCtrl), .result(aluResult));

    loadStoreUnit u_lsu (
        .addrLow(aluResult[1:0]), .storeData(rdata2),
        .memLen(ctrl.memLen), .memSigned(ctrl.memSigned),
        .wdata(dmemWdata), .wmask(dmemWmask),
        .rdata(dmemRdata), .loadData(loadData)
    );

    assign dmemAddr = {aluResult[`XLEN-1:2], 2'b00};
    assign dmemWe   = ctrl.memWrite & rstN;   // Held low during reset

    // Branch comparator
    always_comb begin
        case (funct3)
            3'b000:  taken = (rdata1 == rdata2);
            3'b001:  taken = (rdata1 != rdata2);
            3'b100:  taken = ($signed(rdata1) <  $signed(rdata2));
            3'b101:  taken = ($signed(rdata1) >= $signed(rdata2));
            3'b110:  taken = (rdata1 <  rdata2);
            3'b111:  taken = (rdata1 >= rdata2);
            default: taken = 1'b0;
        endcase
    end

    assign pcPlus4 = pc + 32'd4;

    always_comb begin
        if (ctrl.jumpReg)
            nextPc = {aluResult[`XLEN-1:1], 1'b0};   // JALR clears bit 0
        else if (ctrl.jump || (ctrl.branch && taken))
            nextPc = aluResult;
        else
            nextPc = pcPlus4;
    end

    // Write-back mux
    always_comb begin
        case (ctrl.wbSel)
            `WB_MEM: wbData = loadData;
            `WB_PC4: wbData = pcPlus4;   // Link value
            default: wbData = aluResult;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN)
            pc <= `RESET_PC;
        else
            pc <= nextPc;
    end

endmodule

//--- tbClock.sv
/*
 * Free-running testbench clock. Starts low and toggles every
 * half period, so the first rising edge comes at period/2.
 */
`timescale 1ns/1ps

module tbClock #(
    parameter int period = 40   // ns
) (
    output logic clk
);

    initial clk = 1'b0;

    always #(period / 2) clk = ~clk;

endmodule

//--- cpuCore_assert.sv
/*
 * Memory-port and fetch rules of the core, bound into cpuCore
 * from the testbench. Failures are raised as assertion errors.
 */
`timescale 1ns/1ps

module cpuCore_assert import isaPkg::*; (
    input logic       clk,
    input logic       rstN,
    input wordT       pc,
    input logic       dmemWe,
    input logic [3:0] dmemWmask
);

    weQuietInReset: assert property (@(posedge clk) !rstN |-> !dmemWe)
        else $error("dmemWe is high while rstN is low");

    // A write must enable at least one byte lane
    maskOnWrite: assert property (@(posedge clk) disable iff (!rstN)
                                  dmemWe |-> (dmemWmask != 4'b0000))
        else $error("dmemWe is high with an empty byte mask");

    pcAligned: assert property (@(posedge clk) pc[1:0] == 2'b00)
        else $error("pc is not word aligned");

endmodule

//--- cpuCore_tb.sv
/*
 * Testbench for the single-cycle RV32I core. A program is assembled
 * into the ROM at time zero, then an instruction-level model runs in
 * lockstep and each cycle the fetch address and any data write are
 * compared. At the final self-jump the whole data RAM is compared.
 */
`timescale 1ns/1ps
`include "core_defs.svh"

module cpuCore_tb import isaPkg::*; ();

    localparam int clkPeriod = 40;

    typedef struct packed {
        wordT       nextPc;
        logic       we;
        wordT       addr;
        wordT       data;   // Already masked to the enabled lanes
        logic [3:0] mask;
    } expectT;

    logic       clk, rstN, dmemWe;
    wordT       pc, instr, dmemAddr, dmemWdata, dmemRdata, haltPc;
    logic [3:0] dmemWmask;
    wordT       rom [0:511];
    wordT       ram [0:255];
    wordT       mRam [0:255];   // Model copies
    wordT       mRegs [0:31];
    int         progLen, slot;
    integer     seed;

    tbClock #(.period(clkPeriod)) u_clk (.clk(clk));

    cpuCore i_dut (
        .clk(clk), .rstN(rstN), .pc(pc), .instr(instr),
        .dmemAddr(dmemAddr), .dmemWdata(dmemWdata), .dmemWmask(dmemWmask),
        .dmemWe(dmemWe), .dmemRdata(dmemRdata)
    );

    bind cpuCore cpuCore_assert u_assert (
        .clk(clk), .rstN(rstN), .pc(pc), .dmemWe(dmemWe), .dmemWmask(dmemWmask)
    );

    assign instr     = rom[pc[10:2]];
    assign dmemRdata = ram[dmemAddr[9:2]];

    always @(posedge clk) begin
        if (dmemWe) begin
            for (int k = 0; k < 4; k++) begin
                if (dmemWmask[k])
                    ram[dmemAddr[9:2]][8*k +: 8] <= dmemWdata[8*k +: 8];
            end
        end
    end

    // Builds I-type words and R-type words with {funct7, rs2} as the immediate
    function automatic wordT encI(input logic [11:0] imm, input regIdxT rs1,
                                  input funct3T f3, input regIdxT rd, input opcodeT op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic wordT encS(input logic [11:0] imm, input regIdxT rs2, input funct3T f3);
        return {imm[11:5], rs2, 5'd0, f3, imm[4:0], `OP_STORE};   // Base is always x0
    endfunction

    function automatic wordT encB(input logic [12:0] imm, input regIdxT rs1, input regIdxT rs2,
                                  input funct3T f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `OP_BRANCH};
    endfunction

    function automatic wordT encJ(input logic [20:0] imm, input regIdxT rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `OP_JAL};
    endfunction

    function automatic wordT byteBits(input logic [3:0] m);
        return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
    endfunction

    // Register and immediate group result from the ISA definition
    function automatic wordT opResult(input funct3T f3, input logic alt, input wordT x,
                                      input wordT y);
        wordT r;
        case (f3)
            3'b000:  r = alt ? x - y : x + y;
            3'b001:  r = x << y[4:0];
            3'b010:  r = ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
            3'b011:  r = (x < y) ? 32'd1 : 32'd0;
            3'b100:  r = x ^ y;
            3'b101: begin
                if (alt)
                    r = $unsigned($signed(x) >>> y[4:0]);
                else
                    r = x >> y[4:0];
            end
            3'b110:  r = x | y;
            default: r = x & y;
        endcase
        return r;
    endfunction

    // Executes one instruction on the model state
    function automatic expectT refStep(input wordT curPc);
        expectT e;
        wordT   ins, a, b, immI, addr, lane, rdVal;
        logic   wrRd, taken;
        int     off;
        ins   = rom[curPc[10:2]];
        a     = mRegs[ins[19:15]];
        b     = mRegs[ins[24:20]];
        immI  = {{20{ins[31]}}, ins[31:20]};
        e     = '0;
        e.nextPc = curPc + 32'd4;
        wrRd  = 1'b1;
        rdVal = curPc + 32'd4;   // Link value for the jumps
        case (ins[6:0])
            `OP_LUI:   rdVal = {ins[31:12], 12'h000};
            `OP_AUIPC: rdVal = curPc + {ins[31:12], 12'h000};
            `OP_JAL:   e.nextPc = curPc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            `OP_JALR:  e.nextPc = (a + immI) & 32'hFFFF_FFFE;
            `OP_BRANCH: begin
                wrRd = 1'b0;
                case (ins[14:12])
                    3'b000:  taken = (a == b);
                    3'b001:  taken = (a != b);
                    3'b100:  taken = $signed(a) < $signed(b);
                    3'b101:  taken = !($signed(a) < $signed(b));
                    3'b110:  taken = a < b;
                    3'b111:  taken = !(a < b);
                    default: taken = 1'b0;
                endcase
                if (taken)
                    e.nextPc = curPc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            end
            `OP_LOAD: begin
                addr = a + immI;
                off  = int'(addr[1:0]);
                lane = mRam[addr[9:2]] >> (8 * off);
                case (ins[14:12])
                    3'b000:  rdVal = {{24{lane[7]}}, lane[7:0]};
                    3'b001:  rdVal = {{16{lane[15]}}, lane[15:0]};
                    3'b100:  rdVal = {24'h0, lane[7:0]};
                    3'b101:  rdVal = {16'h0, lane[15:0]};
                    default: rdVal = lane;
                endcase
            end
            `OP_STORE: begin
                wrRd   = 1'b0;
                addr   = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                off    = int'(addr[1:0]);
                e.we   = 1'b1;
                e.addr = {addr[31:2], 2'b00};
                e.mask = (ins[13:12] == 2'b00) ? 4'b0001 << off :
                         (ins[13:12] == 2'b01) ? 4'b0011 << off : 4'b1111;
                e.data = (b << (8 * off)) & byteBits(e.mask);
                mRam[addr[9:2]] = (mRam[addr[9:2]] & ~byteBits(e.mask)) | e.data;
            end
            `OP_OPIMM: rdVal = opResult(ins[14:12], ins[30] && (ins[14:12] == 3'b101), a, immI);
            `OP_OP:    rdVal = opResult(ins[14:12], ins[30], a, b);
            default:   wrRd = 1'b0;   // Unknown opcode acts as a no-op
        endcase
        if (wrRd && (ins[11:7] != 5'd0))
            mRegs[ins[11:7]] = rdVal;
        return e;
    endfunction

    task automatic emit(input wordT w);
        rom[progLen[8:0]] = w;
        progLen++;
    endtask

    // LUI + ADDI pair with the upper part rounded for the sign of the low 12 bits
    task automatic loadConst(input regIdxT rd, input wordT value);
        wordT upper;
        upper = value + 32'h800;
        emit({upper[31:12], rd, `OP_LUI});
        emit(encI(value[11:0], rd, 3'b000, rd, `OP_OPIMM));
    endtask

    task automatic storeWord(input regIdxT rs);
        emit(encS(slot[11:0], rs, 3'b010));
        slot += 4;
    endtask

    task automatic buildProgram();
        funct3T rOps [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
        logic   rAlt [10] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
        funct3T iOps [6]  = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7};
        funct3T bOps [6]  = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        regIdxT tA [6] = '{5'd11, 5'd10, 5'd10, 5'd11, 5'd11, 5'd10};   // Taken pairs
        regIdxT tB [6] = '{5'd12, 5'd11, 5'd11, 5'd10, 5'd10, 5'd11};
        regIdxT nA [6] = '{5'd10, 5'd11, 5'd11, 5'd10, 5'd10, 5'd11};   // Not-taken pairs
        regIdxT nB [6] = '{5'd11, 5'd12, 5'd10, 5'd11, 5'd11, 5'd10};
        wordT   a, b, r, target;
        storeWord(5'd0);   // Store at RESET_PC is fetched throughout reset
        for (int round = 0; round < 2; round++) begin
            a = $random(seed);
            b = $random(seed);
            if (round == 1) begin   // Force the signed and unsigned orders apart
                a[31] = 1'b1;
                b[31] = 1'b0;
            end
            loadConst(5'd1, a);
            loadConst(5'd2, b);
            for (int k = 0; k < 10; k++) begin
                emit(encI({1'b0, rAlt[k], 5'b0, 5'd2}, 5'd1, rOps[k], 5'd5, `OP_OP));
                storeWord(5'd5);
            end
            for (int k = 0; k < 9; k++) begin
                r = $random(seed);
                if (k < 6)
                    emit(encI(r[11:0], 5'd1, iOps[k], 5'd5, `OP_OPIMM));
                else   // SLLI, SRLI, SRAI
                    emit(encI({1'b0, k == 8, 5'b0, r[4:0]}, 5'd1, (k == 6) ? 3'b001 : 3'b101,
                              5'd5, `OP_OPIMM));
                storeWord(5'd5);
            end
        end
        loadConst(5'd6, $random(seed));
        for (int k = 0; k < 4; k++)
            emit(encS(12'(32'h300 + k), 5'd6, 3'b000));
        emit(encS(12'h304, 5'd6, 3'b001));
        emit(encS(12'h306, 5'd6, 3'b001));
        emit(encS(12'h308, 5'd6, 3'b010));
        for (int k = 0; k < 4; k++) begin   // LB/LBU, LH/LHU and LW from the preset word
            for (int u = 0; u < 2; u++) begin
                if (k < 2 || u == 0) begin
                    emit(encI(12'(32'h200 + ((k < 2) ? 2 * k : 0) + ((k == 3) ? k : 0)),
                              5'd0, {u[0], (k < 2) ? 2'b01 : 2'b00}, 5'd7, `OP_LOAD));
                    storeWord(5'd7);
                end
            end
            emit(encI(12'(32'h200 + k), 5'd0, 3'b100, 5'd7, `OP_LOAD));
            storeWord(5'd7);
            emit(encI(12'(32'h200 + k), 5'd0, 3'b000, 5'd7, `OP_LOAD));
            storeWord(5'd7);
        end
        emit(encI(12'h200, 5'd0, 3'b010, 5'd7, `OP_LOAD));
        storeWord(5'd7);
        loadConst(5'd10, 32'hFFFF_FFFB);
        loadConst(5'd11, 32'd3);
        loadConst(5'd12, 32'd3);
        for (int k = 0; k < 6; k++) begin   // Each branch skips one counter increment
            emit(encB(13'd8, tA[k], tB[k], bOps[k]));
            emit(encI(12'd1, 5'd13, 3'b000, 5'd13, `OP_OPIMM));
            emit(encB(13'd8, nA[k], nB[k], bOps[k]));
            emit(encI(12'd1, 5'd13, 3'b000, 5'd13, `OP_OPIMM));
        end
        emit(encJ(21'd8, 5'd14));
        emit(encI(12'd1, 5'd13, 3'b000, 5'd13, `OP_OPIMM));
        storeWord(5'd14);
        target = wordT'((progLen + 4) * 4);   // Past LUI, ADDI, JALR and one skipped word
        loadConst(5'd15, target - 32'd4);
        emit(encI(12'd5, 5'd15, 3'b000, 5'd16, `OP_JALR));   // Odd sum with bit 0 dropped
        emit(encI(12'd1, 5'd13, 3'b000, 5'd13, `OP_OPIMM));
        storeWord(5'd16);
        storeWord(5'd13);
        r = $random(seed);
        emit(encI(r[11:0], 5'd0, 3'b000, 5'd0, `OP_OPIMM));   // Write to x0
        storeWord(5'd0);
        r = $random(seed);
        emit({r[19:0], 5'd17, `OP_LUI});
        storeWord(5'd17);
        r = $random(seed);
        emit({r[19:0], 5'd18, `OP_AUIPC});
        storeWord(5'd18);
        emit(encI({7'h00, 5'd1}, 5'd2, 3'b000, 5'd5, 7'b0001011));   // Custom opcode
        storeWord(5'd5);
        haltPc = wordT'(progLen * 4);
        emit(encJ(21'd0, 5'd0));
    endtask

    task automatic reportMismatch(input string name, input wordT got, input wordT want);
        $display("ERR %0d ns: %s is %h, expected %h", $time, name, got, want);
        $display("Verification failed");
        $fatal(1, "%s mismatch", name);
    endtask

    initial begin : stimulus
        rstN    = 1'b0;
        seed    = 32'h7ca6;
        progLen = 0;
        slot    = 0;
        for (int i = 0; i < 512; i++)
            rom[i] = '0;
        for (int i = 0; i < 256; i++)
            ram[i] = (wordT'(i) << 2) * 32'h9E37_79B9;   // Hash of the byte address
        ram[128] = 32'h80F1_7F81;   // Load source at 0x200 with mixed sign bytes
        buildProgram();
        for (int i = 0; i < 256; i++)
            mRam[i] = ram[i];
        for (int i = 0; i < 32; i++)
            mRegs[i] = '0;
        repeat (5) @(posedge clk);
        #1 rstN = 1'b1;
    end

    initial begin : compare
        expectT want;
        wordT   expPc;
        int     haltCycles;
        expPc      = `RESET_PC;
        haltCycles = 0;
        @(posedge rstN);
        #(clkPeriod - 3);   // 2 ns before the first working edge
        while (haltCycles < 2) begin
            want = refStep(expPc);
            assert (pc === expPc) else reportMismatch("pc", pc, expPc);
            assert (dmemWe === want.we)
                else reportMismatch("dmemWe", wordT'(dmemWe), wordT'(want.we));
            if (want.we) begin
                assert (dmemAddr === want.addr) else reportMismatch("dmemAddr", dmemAddr, want.addr);
                assert (dmemWmask === want.mask)
                    else reportMismatch("dmemWmask", wordT'(dmemWmask), wordT'(want.mask));
                assert ((dmemWdata & byteBits(want.mask)) === want.data)
                    else reportMismatch("dmemWdata", dmemWdata & byteBits(want.mask), want.data);
            end
            if (pc == haltPc)
                haltCycles++;
            expPc = want.nextPc;
            @(posedge clk);
            #(clkPeriod - 2);
        end
        for (int i = 0; i < 256; i++) begin
            assert (ram[i] === mRam[i])
                else reportMismatch($sformatf("ram[%0d]", i), ram[i], mRam[i]);
        end
        $display("Verification passed");
        $finish;
    end

    initial begin : watchdog
        @(posedge rstN);
        #((progLen + 50) * clkPeriod);
        $display("Verification failed");
        $fatal(1, "Timeout, the core never settled on the final self-jump");
    end

endmodule

//--- flist.f
+incdir+.
isaPkg.sv
ctrlPkg.sv
controller.sv
alu.sv
regFile.sv
immGen.sv
loadStoreUnit.sv
cpuCore.sv
tbClock.sv
cpuCore_assert.sv
cpuCore_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module cpuCore_tb -o simv
	./obj_dir/simv

clean:
	rm -rf obj_dir
